// File: design/pd_pkg.sv
package pd_pkg;

	// raw greyscale pixel as it arrives from the image source
	typedef logic [3:0] pixel_t;

	// laplacian output, 4*15 at most on either side, so 8 bits signed is plenty
	typedef logic signed [7:0] lap_t;

	// correlation sum, sized for a 5x5 template with full-range weights
	typedef logic signed [19:0] corr_t;

	typedef logic signed [7:0] weight_t;

	typedef logic [7:0] count_t;

	// states of the detection counter
	typedef enum logic [1:0] {
		COUNT_IDLE   = 2'd0,
		COUNT_RUN    = 2'd1,
		COUNT_REPORT = 2'd2
	} count_state_e;

	// zero extends a pixel into the signed laplacian range
	function automatic lap_t pix_to_lap(pixel_t p);
		lap_t v;
		v = lap_t'({{($bits(lap_t) - $bits(pixel_t)){1'b0}}, p});
		return v;
	endfunction

	// signed maximum of two correlation values
	function automatic corr_t corr_max(corr_t a, corr_t b);
		corr_t m;
		if (a >= b) begin
			m = a;
		end else begin
			m = b;
		end
		return m;
	endfunction

endpackage

// File: design/pix_stream_if.sv
`timescale 1ns/1ps

// valid-only sample stream between pipeline stages, no back-pressure
interface pix_stream_if #(
	parameter int dw = 8
);

	logic valid;
	logic signed [dw-1:0] data;
	// last sample of a row
	logic eol;
	// last sample of a frame, always raised together with eol
	logic eof;

	modport producer (
		output valid,
		output data,
		output eol,
		output eof
	);

	modport consumer (
		input valid,
		input data,
		input eol,
		input eof
	);

endinterface

// File: design/sliding_window.sv
`timescale 1ns/1ps

module sliding_window #(
	parameter int cols = 16,
	parameter int rows = 16,
	parameter int k = 3,
	parameter int dw = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  logic [dw-1:0] in_data,
	output logic win_valid,
	output logic [k*k-1:0][dw-1:0] win_data,
	output logic win_eol,
	output logic win_eof
);

	localparam int cw = (cols > 1) ? $clog2(cols) : 1;
	localparam int rw = (rows > 1) ? $clog2(rows) : 1;

	logic [cw-1:0] col_q;
	logic [rw-1:0] row_q;

	// line buffer 0 holds the previous row, line buffer k-2 the oldest row
	logic [dw-1:0] line_mem [k-1][cols];

	// the k-1 older columns of the window, row 0 is the oldest image row
	logic [dw-1:0] hist_q [k][k-1];

	// column completed by the current pixel, top to bottom
	logic [dw-1:0] col_vec [k];

	always_comb begin
		for (int r = 0; r < k - 1; r++) begin
			col_vec[r] = line_mem[k-2-r][col_q];
		end
		col_vec[k-1] = in_data;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			line_mem[0][col_q] <= in_data;
			for (int i = 1; i < k - 1; i++) begin
				line_mem[i][col_q] <= line_mem[i-1][col_q];
			end
			for (int r = 0; r < k; r++) begin
				for (int c = 0; c < k - 2; c++) begin
					hist_q[r][c] <= hist_q[r][c+1];
				end
				hist_q[r][k-2] <= col_vec[r];
			end
		end
	end

	// raster position of the incoming pixel
	always_ff @(posedge clk) begin
		if (rst) begin
			col_q <= '0;
			row_q <= '0;
		end else if (in_valid) begin
			if (col_q == cw'(cols - 1)) begin
				col_q <= '0;
				row_q <= (row_q == rw'(rows - 1)) ? '0 : row_q + 1'b1;
			end else begin
				col_q <= col_q + 1'b1;
			end
		end
	end

	// the newest column comes straight from the input, so the window is complete
	// in the same cycle as the pixel that closes it
	always_comb begin
		for (int r = 0; r < k; r++) begin
			for (int c = 0; c < k - 1; c++) begin
				win_data[r*k+c] = hist_q[r][c];
			end
			win_data[r*k+k-1] = col_vec[r];
		end
	end

	assign win_valid = in_valid && (row_q >= rw'(k - 1)) && (col_q >= cw'(k - 1));
	assign win_eol = win_valid && (col_q == cw'(cols - 1));
	assign win_eof = win_eol && (row_q == rw'(rows - 1));

endmodule

// File: design/laplace_stage.sv
`timescale 1ns/1ps

module laplace_stage import pd_pkg::*; #(
	parameter int img_cols = 16,
	parameter int img_rows = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic pix_valid,
	input  pixel_t pix_data,
	pix_stream_if.producer lap_out
);

	logic win_valid;
	logic win_eol;
	logic win_eof;
	logic [8:0][$bits(pixel_t)-1:0] win;
	lap_t lap_val;

	sliding_window #(
		.cols(img_cols),
		.rows(img_rows),
		.k(3),
		.dw($bits(pixel_t))
	) u_window (
		.clk(clk),
		.rst(rst),
		.in_valid(pix_valid),
		.in_data(pix_data),
		.win_valid(win_valid),
		.win_data(win),
		.win_eol(win_eol),
		.win_eof(win_eof)
	);

	// cross kernel: centre at index 4, north 1, west 3, east 5, south 7
	assign lap_val = (pix_to_lap(win[4]) <<< 2)
		- pix_to_lap(win[1]) - pix_to_lap(win[7])
		- pix_to_lap(win[3]) - pix_to_lap(win[5]);

	always_ff @(posedge clk) begin
		if (rst) begin
			lap_out.valid <= 1'b0;
			lap_out.eol <= 1'b0;
			lap_out.eof <= 1'b0;
		end else begin
			lap_out.valid <= win_valid;
			lap_out.eol <= win_eol;
			lap_out.eof <= win_eof;
		end
	end

	always_ff @(posedge clk) begin
		if (win_valid) begin
			lap_out.data <= lap_val;
		end
	end

endmodule

// File: design/correlate_stage.sv
`timescale 1ns/1ps

module correlate_stage import pd_pkg::*; #(
	parameter int cols = 14,
	parameter int rows = 14,
	parameter int tmpl_k = 3
) (
	input  logic clk,
	input  logic rst,
	input  logic tmpl_wr,
	input  logic [$clog2(tmpl_k*tmpl_k)-1:0] tmpl_addr,
	input  weight_t tmpl_data,
	pix_stream_if.consumer lap_in,
	pix_stream_if.producer corr_out
);

	localparam int nt = tmpl_k * tmpl_k;
	localparam int pw = $bits(lap_t) + $bits(weight_t);

	logic win_valid;
	logic win_eol;
	logic win_eof;
	logic [nt-1:0][$bits(lap_t)-1:0] win;

	// template weights in row-major order, written between frames
	weight_t weights [nt];

	logic signed [pw-1:0] prod_q [nt];
	logic prod_valid_q;
	logic prod_eol_q;
	logic prod_eof_q;
	corr_t acc;

	sliding_window #(
		.cols(cols),
		.rows(rows),
		.k(tmpl_k),
		.dw($bits(lap_t))
	) u_window (
		.clk(clk),
		.rst(rst),
		.in_valid(lap_in.valid),
		.in_data(lap_in.data),
		.win_valid(win_valid),
		.win_data(win),
		.win_eol(win_eol),
		.win_eof(win_eof)
	);

	always_ff @(posedge clk) begin
		if (tmpl_wr && (tmpl_addr < nt)) begin
			weights[tmpl_addr] <= tmpl_data;
		end
	end

	// first cycle: one product per window element
	always_ff @(posedge clk) begin
		if (win_valid) begin
			for (int i = 0; i < nt; i++) begin
				prod_q[i] <= lap_t'(win[i]) * weights[i];
			end
		end
	end

	// second cycle: adder tree over the registered products
	always_comb begin
		acc = '0;
		for (int i = 0; i < nt; i++) begin
			acc = acc + corr_t'(prod_q[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid_q) begin
			corr_out.data <= acc;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid_q <= 1'b0;
			prod_eol_q <= 1'b0;
			prod_eof_q <= 1'b0;
			corr_out.valid <= 1'b0;
			corr_out.eol <= 1'b0;
			corr_out.eof <= 1'b0;
		end else begin
			prod_valid_q <= win_valid;
			prod_eol_q <= win_eol;
			prod_eof_q <= win_eof;
			corr_out.valid <= prod_valid_q;
			corr_out.eol <= prod_eol_q;
			corr_out.eof <= prod_eof_q;
		end
	end

endmodule

// File: design/max_pool_stage.sv
`timescale 1ns/1ps

module max_pool_stage import pd_pkg::*; #(
	parameter int out_cols = 12
) (
	input  logic clk,
	input  logic rst,
	pix_stream_if.consumer corr_in,
	pix_stream_if.producer pool_out
);

	localparam int pairs = out_cols / 2;
	localparam int iw = (pairs > 1) ? $clog2(pairs + 1) : 1;

	logic col_odd_q;
	logic row_odd_q;
	logic [iw-1:0] pair_q;
	corr_t even_q;
	// pairwise maxima of the last even row, one entry per column pair
	corr_t row_buf [pairs];
	corr_t in_val;
	corr_t pair_max;
	logic block_done;
	logic last_pair;

	assign in_val = corr_in.data;
	assign pair_max = corr_max(even_q, in_val);
	assign block_done = corr_in.valid && col_odd_q && row_odd_q;
	assign last_pair = (pair_q == iw'(pairs - 1));

	// parity and pair position; a trailing odd column never reaches an odd slot
	always_ff @(posedge clk) begin
		if (rst) begin
			col_odd_q <= 1'b0;
			row_odd_q <= 1'b0;
			pair_q <= '0;
		end else if (corr_in.valid) begin
			if (corr_in.eol) begin
				col_odd_q <= 1'b0;
				pair_q <= '0;
				row_odd_q <= corr_in.eof ? 1'b0 : !row_odd_q;
			end else begin
				col_odd_q <= !col_odd_q;
				if (col_odd_q) begin
					pair_q <= pair_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (corr_in.valid) begin
			if (!col_odd_q) begin
				even_q <= in_val;
			end else if (!row_odd_q) begin
				row_buf[pair_q] <= pair_max;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (block_done) begin
			pool_out.data <= corr_max(row_buf[pair_q], pair_max);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pool_out.valid <= 1'b0;
			pool_out.eol <= 1'b0;
			pool_out.eof <= 1'b0;
		end else begin
			pool_out.valid <= block_done;
			pool_out.eol <= block_done && last_pair;
			pool_out.eof <= block_done && last_pair && corr_in.eof;
		end
	end

endmodule

// File: design/detect_counter.sv
`timescale 1ns/1ps

module detect_counter import pd_pkg::*; #(
	parameter corr_t threshold = 20'sd40
) (
	input  logic clk,
	input  logic rst,
	pix_stream_if.consumer pool_in,
	output count_t detect_count,
	output logic frame_done
);

	count_state_e state_q;
	count_t run_q;
	count_t base;
	count_t next_cnt;
	logic hit;

	assign hit = (pool_in.data >= threshold);

	// a frame starts from zero unless a count is already running
	assign base = (state_q == COUNT_RUN) ? run_q : '0;
	assign next_cnt = base + count_t'(hit);

	assign frame_done = (state_q == COUNT_REPORT);

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= COUNT_IDLE;
			run_q <= '0;
			detect_count <= '0;
		end else begin
			case (state_q)
				COUNT_RUN: begin
					if (pool_in.valid) begin
						run_q <= next_cnt;
						if (pool_in.eof) begin
							detect_count <= next_cnt;
							state_q <= COUNT_REPORT;
						end
					end
				end
				default: begin
					// idle, or the single report cycle of the previous frame
					if (pool_in.valid) begin
						run_q <= next_cnt;
						if (pool_in.eof) begin
							detect_count <= next_cnt;
							state_q <= COUNT_REPORT;
						end else begin
							state_q <= COUNT_RUN;
						end
					end else begin
						state_q <= COUNT_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// File: design/pattern_detect_top.sv
`timescale 1ns/1ps

module pattern_detect_top import pd_pkg::*; #(
	parameter int img_cols = 16,
	parameter int img_rows = 16,
	parameter int tmpl_k = 3,
	parameter corr_t threshold = 20'sd40
) (
	input  logic clk,
	input  logic rst,
	input  logic pix_valid,
	input  pixel_t pix_data,
	input  logic tmpl_wr,
	input  logic [$clog2(tmpl_k*tmpl_k)-1:0] tmpl_addr,
	input  weight_t tmpl_data,
	output count_t detect_count,
	output logic frame_done
);

	// the laplacian drops a one-pixel border, the correlation a further k-1
	localparam int lap_cols = img_cols - 2;
	localparam int lap_rows = img_rows - 2;
	localparam int corr_cols = lap_cols - tmpl_k + 1;

	pix_stream_if #(.dw($bits(lap_t))) lap_s ();
	pix_stream_if #(.dw($bits(corr_t))) corr_s ();
	pix_stream_if #(.dw($bits(corr_t))) pool_s ();

	laplace_stage #(
		.img_cols(img_cols),
		.img_rows(img_rows)
	) u_laplace (
		.clk(clk),
		.rst(rst),
		.pix_valid(pix_valid),
		.pix_data(pix_data),
		.lap_out(lap_s)
	);

	correlate_stage #(
		.cols(lap_cols),
		.rows(lap_rows),
		.tmpl_k(tmpl_k)
	) u_correlate (
		.clk(clk),
		.rst(rst),
		.tmpl_wr(tmpl_wr),
		.tmpl_addr(tmpl_addr),
		.tmpl_data(tmpl_data),
		.lap_in(lap_s),
		.corr_out(corr_s)
	);

	max_pool_stage #(
		.out_cols(corr_cols)
	) u_pool (
		.clk(clk),
		.rst(rst),
		.corr_in(corr_s),
		.pool_out(pool_s)
	);

	detect_counter #(
		.threshold(threshold)
	) u_detect (
		.clk(clk),
		.rst(rst),
		.pool_in(pool_s),
		.detect_count(detect_count),
		.frame_done(frame_done)
	);

endmodule

// File: verification/pd_assert.sv
`timescale 1ns/1ps

module pd_assert import pd_pkg::*; (
	input logic clk,
	input logic rst,
	input logic pix_valid,
	input count_t detect_count,
	input logic frame_done
);

	// set once a pixel has entered since the last frame_done
	logic pix_seen_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			pix_seen_q <= 1'b0;
		end else if (frame_done) begin
			pix_seen_q <= pix_valid;
		end else if (pix_valid) begin
			pix_seen_q <= 1'b1;
		end
	end

	done_single_pulse: assert property (@(posedge clk) disable iff (rst)
		frame_done |=> !frame_done)
		else $error("frame_done stayed high for more than one cycle");

	count_stable: assert property (@(posedge clk) disable iff (rst)
		$changed(detect_count) |-> frame_done)
		else $error("detect_count changed outside a frame_done cycle");

	done_after_pixels: assert property (@(posedge clk) disable iff (rst)
		frame_done |-> pix_seen_q)
		else $error("frame_done without pixel input since the previous one");

	outputs_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown({frame_done, detect_count}))
		else $error("unknown value on frame_done or detect_count");

endmodule

bind pattern_detect_top pd_assert u_pd_assert (
	.clk(clk),
	.rst(rst),
	.pix_valid(pix_valid),
	.detect_count(detect_count),
	.frame_done(frame_done)
);

// File: verification/tb_pattern_detect.sv
`timescale 1ns/1ps

module tb_pattern_detect;

	localparam int img_n = 16;
	localparam int lap_n = img_n - 2;
	localparam int tmpl_k = 3;
	localparam int corr_n = lap_n - tmpl_k + 1;
	localparam int pool_n = corr_n / 2;
	localparam int threshold = 40;
	localparam int n_frames = 9;
	localparam int max_gap = 3;
	// every frame may carry up to max_gap idle cycles after each pixel
	localparam int timeout_limit = n_frames * img_n * img_n * (1 + max_gap) + 2000;

	logic clk;
	logic rst;
	logic pix_valid;
	logic [3:0] pix_data;
	logic tmpl_wr;
	logic [3:0] tmpl_addr;
	logic [7:0] tmpl_data;
	logic [7:0] detect_count;
	logic frame_done;

	int img [img_n][img_n];
	int wts [tmpl_k*tmpl_k];
	int exp_q [$];
	int exp_count;
	int errors = 0;
	int frames_sent = 0;
	int frames_done = 0;
	int cycles = 0;
	logic [31:0] lfsr_q = 32'hc5947923;

	pattern_detect_top UUT (
		.clk(clk),
		.rst(rst),
		.pix_valid(pix_valid),
		.pix_data(pix_data),
		.tmpl_wr(tmpl_wr),
		.tmpl_addr(tmpl_addr),
		.tmpl_data(tmpl_data),
		.detect_count(detect_count),
		.frame_done(frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_q[0]);
			lfsr_q = lfsr_step(lfsr_q);
		end
		return v;
	endfunction

	// laplacian, correlation, 2x2 pooling and threshold count of the current image
	function automatic int model_count();
		int lap [lap_n][lap_n];
		int corr [corr_n][corr_n];
		int cnt;
		int best;
		int v;
		cnt = 0;
		for (int r = 0; r < lap_n; r++) begin
			for (int c = 0; c < lap_n; c++) begin
				lap[r][c] = 4 * img[r+1][c+1] - img[r][c+1] - img[r+2][c+1]
					- img[r+1][c] - img[r+1][c+2];
			end
		end
		for (int r = 0; r < corr_n; r++) begin
			for (int c = 0; c < corr_n; c++) begin
				v = 0;
				for (int i = 0; i < tmpl_k; i++) begin
					for (int j = 0; j < tmpl_k; j++) begin
						v = v + wts[i*tmpl_k+j] * lap[r+i][c+j];
					end
				end
				corr[r][c] = v;
			end
		end
		for (int pr = 0; pr < pool_n; pr++) begin
			for (int pc = 0; pc < pool_n; pc++) begin
				best = corr[2*pr][2*pc];
				for (int d = 1; d < 4; d++) begin
					if (corr[2*pr+d/2][2*pc+d%2] > best) begin
						best = corr[2*pr+d/2][2*pc+d%2];
					end
				end
				if (best >= threshold) begin
					cnt++;
				end
			end
		end
		return cnt;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	function automatic void fill_random_image();
		for (int r = 0; r < img_n; r++) begin
			for (int c = 0; c < img_n; c++) begin
				img[r][c] = take_bits(4);
			end
		end
	endfunction

	function automatic void set_random_weights();
		for (int i = 0; i < tmpl_k * tmpl_k; i++) begin
			wts[i] = take_bits(8);
			if (wts[i] >= 128) begin
				wts[i] = wts[i] - 256;
			end
			// keeps the negated template inside the 8-bit range
			if (wts[i] == -128) begin
				wts[i] = -127;
			end
		end
	endfunction

	task automatic load_template();
		for (int i = 0; i < tmpl_k * tmpl_k; i++) begin
			@(negedge clk);
			tmpl_wr = 1'b1;
			tmpl_addr = i[3:0];
			tmpl_data = wts[i][7:0];
		end
		@(negedge clk);
		tmpl_wr = 1'b0;
	endtask

	task automatic queue_frame();
		exp_q.push_back(model_count());
		frames_sent++;
	endtask

	task automatic stream_image(input bit with_gaps);
		int n;
		for (int r = 0; r < img_n; r++) begin
			for (int c = 0; c < img_n; c++) begin
				@(negedge clk);
				pix_valid = 1'b1;
				pix_data = img[r][c][3:0];
				if (with_gaps) begin
					n = take_bits(2);
					repeat (n) begin
						@(negedge clk);
						pix_valid = 1'b0;
					end
				end
			end
		end
	endtask

	task automatic end_stream();
		@(negedge clk);
		pix_valid = 1'b0;
	endtask

	task automatic wait_all_frames();
		while (frames_done < frames_sent) begin
			@(negedge clk);
		end
	endtask

	task automatic idle_after_reset();
		repeat (6) begin
			@(negedge clk);
			check_val("frame_done", 32'(frame_done), 32'd0);
			check_val("detect_count", 32'(detect_count), 32'd0);
		end
	endtask

	task automatic flat_image_frame();
		wts = '{0, -1, 0, -1, 4, -1, 0, -1, 0};
		load_template();
		for (int r = 0; r < img_n; r++) begin
			for (int c = 0; c < img_n; c++) begin
				img[r][c] = 9;
			end
		end
		queue_frame();
		stream_image(1'b0);
		end_stream();
		wait_all_frames();
		repeat (40) @(negedge clk);
		check_val("frame_done pulses", 32'(frames_done), 32'(frames_sent));
	endtask

	// a lone bright pixel gives a cross-shaped laplacian that matches the cross template
	task automatic planted_cross_frame();
		wts = '{0, -1, 0, -1, 4, -1, 0, -1, 0};
		load_template();
		for (int r = 0; r < img_n; r++) begin
			for (int c = 0; c < img_n; c++) begin
				img[r][c] = 0;
			end
		end
		img[6][7] = 15;
		queue_frame();
		stream_image(1'b0);
		end_stream();
		wait_all_frames();
		// only the pooling block around the bright pixel reaches the threshold
		check_val("detect_count", 32'(detect_count), 32'd1);
	endtask

	task automatic random_gap_frames();
		set_random_weights();
		load_template();
		repeat (3) begin
			fill_random_image();
			queue_frame();
			stream_image(1'b1);
			end_stream();
			wait_all_frames();
		end
	endtask

	task automatic template_reload_frames();
		set_random_weights();
		load_template();
		fill_random_image();
		queue_frame();
		stream_image(1'b0);
		end_stream();
		wait_all_frames();
		for (int i = 0; i < tmpl_k * tmpl_k; i++) begin
			wts[i] = -wts[i];
		end
		load_template();
		queue_frame();
		stream_image(1'b0);
		end_stream();
		wait_all_frames();
	endtask

	task automatic back_to_back_frames();
		fill_random_image();
		queue_frame();
		stream_image(1'b0);
		fill_random_image();
		queue_frame();
		stream_image(1'b0);
		end_stream();
		wait_all_frames();
	endtask

	// every frame_done is matched against the oldest outstanding frame
	always @(negedge clk) begin
		if (!rst && frame_done) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("frame_done was raised while no frame was outstanding");
			end else begin
				exp_count = exp_q.pop_front();
				check_val("detect_count", 32'(detect_count), 32'(exp_count));
			end
			frames_done++;
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= timeout_limit) begin
			$display("timeout after %0d cycles, %0d of %0d frames finished",
				cycles, frames_done, frames_sent);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		pix_valid = 1'b0;
		pix_data = '0;
		tmpl_wr = 1'b0;
		tmpl_addr = '0;
		tmpl_data = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		idle_after_reset();
		flat_image_frame();
		planted_cross_frame();
		random_gap_frames();
		template_reload_frames();
		back_to_back_frames();
		repeat (20) @(negedge clk);
		check_val("frames finished", 32'(frames_done), 32'(frames_sent));
		$display("errors: %0d, frames checked: %0d", errors, frames_done);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: build.f
design/pd_pkg.sv
design/pix_stream_if.sv
design/sliding_window.sv
design/laplace_stage.sv
design/correlate_stage.sv
design/max_pool_stage.sv
design/detect_counter.sv
design/pattern_detect_top.sv
verification/pd_assert.sv
verification/tb_pattern_detect.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module tb_pattern_detect -o sim_pattern_detect
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_pattern_detect)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation ended with an error status"
	exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
	exit 0
fi
exit 1
